// ==== filelist.f ====
+incdir+include
rtl/axi_pkg.sv
rtl/sram_pkg.sv
rtl/sram_mem_if.sv
rtl/axi_burst_addr.sv
rtl/sram_array.sv
rtl/axi_rd_engine.sv
rtl/axi_wr_engine.sv
rtl/sram_axi4.sv
verif/tb_sram_axi4.sv

// ==== include/sram_defs.svh ====
// Widths fixed for a 2 KB array of 64-bit words; only full-width (8-byte) beats are legal
`ifndef SRAM_DEFS_SVH
`define SRAM_DEFS_SVH

// ====================
// Data path
// ====================

// Word width, also the AXI data bus width
`define SRAM_DATA_W 64

// Number of words in the array
`define SRAM_DEPTH 256

// ====================
// AXI side
// ====================

// Byte address, covers 2 KB
`define SRAM_ADDR_W 11

// Transaction ID carried from AR/AW to R/B
`define SRAM_ID_W 4

`endif

// ==== rtl/axi_burst_addr.sv ====
// Word-granular sequencer; assumes full-width beats, so low address bits are dropped
`timescale 1ns/10ps
`include "sram_defs.svh"

module axi_burst_addr (
    input  logic                    i_aclk,
    input  logic                    i_areset_n,
    input  logic                    i_load,
    input  logic [`SRAM_ADDR_W-1:0] i_addr,
    input  axi_pkg::len_t           i_len,
    input  axi_pkg::burst_e         i_burst,
    input  logic                    i_step,
    output sram_pkg::widx_t         o_idx
);

    sram_pkg::widx_t r_idx;
    sram_pkg::widx_t r_mask;
    axi_pkg::burst_e r_burst;
    sram_pkg::widx_t w_idx_inc;
    sram_pkg::widx_t w_idx_wrap;

    assign w_idx_inc = r_idx + 1'b1;

    // Upper bits stay in the aligned block, lower bits roll over
    assign w_idx_wrap = (r_idx & ~r_mask) | (w_idx_inc & r_mask);

    always_ff @(posedge i_aclk) begin
        if (!i_areset_n) begin
            r_idx   <= '0;
            r_mask  <= '0;
            r_burst <= axi_pkg::BURST_FIXED;
        end else if (i_load) begin
            r_idx   <= i_addr[sram_pkg::OFFS_W +: sram_pkg::IDX_W];
            // For legal WRAP lengths, len is beats-1, i.e. the block mask
            r_mask  <= sram_pkg::widx_t'(i_len);
            r_burst <= i_burst;
        end else if (i_step) begin
            case (r_burst)
                axi_pkg::BURST_INCR: begin
                    r_idx <= w_idx_inc;
                end
                axi_pkg::BURST_WRAP: begin
                    r_idx <= w_idx_wrap;
                end
                default: begin
                    // FIXED and reserved codes stay on one word
                    r_idx <= r_idx;
                end
            endcase
        end
    end

    assign o_idx = r_idx;

endmodule

// ==== rtl/axi_pkg.sv ====
// AXI4 burst and response encodings; reserved burst code 2'b11 passes legality like FIXED
`include "sram_defs.svh"

package axi_pkg;

    // Burst type as coded on AxBURST
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_e;

    // Only the two responses this slave produces
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    typedef logic [7:0] len_t;
    typedef logic [2:0] size_t;

    // Size code of a full bus-width beat
    localparam size_t FULL_SIZE = size_t'($clog2(`SRAM_DATA_W / 8));

    // Full-width beats only, WRAP restricted to 2/4/8/16 beats
    function automatic logic burst_legal(input size_t size, input burst_e burst,
                                         input len_t len);
        logic size_ok;
        logic len_ok;
        size_ok = (size == FULL_SIZE);
        len_ok  = (burst != BURST_WRAP) || (len == 8'd1) || (len == 8'd3) ||
                  (len == 8'd7) || (len == 8'd15);
        return size_ok && len_ok;
    endfunction

endpackage

// ==== rtl/axi_rd_engine.sv ====
// One read burst at a time; illegal bursts skip the array and answer SLVERR on every beat
`timescale 1ns/10ps
`include "sram_defs.svh"

module axi_rd_engine (
    input  logic                    i_aclk,
    input  logic                    i_areset_n,
    // AR channel
    input  logic [`SRAM_ID_W-1:0]   i_arid,
    input  logic [`SRAM_ADDR_W-1:0] i_araddr,
    input  axi_pkg::len_t           i_arlen,
    input  axi_pkg::size_t          i_arsize,
    input  axi_pkg::burst_e         i_arburst,
    input  logic                    i_arvalid,
    output logic                    o_arready,
    // R channel, data comes from the array
    output logic [`SRAM_ID_W-1:0]   o_rid,
    output axi_pkg::resp_e          o_rresp,
    output logic                    o_rlast,
    output logic                    o_rvalid,
    input  logic                    i_rready,
    sram_mem_if.rd_port             mem
);

    typedef enum logic {
        RD_IDLE,
        RD_BURST
    } rd_state_e;

    rd_state_e              r_state;
    logic [`SRAM_ID_W-1:0]  r_rid;
    axi_pkg::len_t          r_len;
    logic                   r_legal;
    // Needs a ninth bit to count past 256 issued beats
    logic [8:0]             r_issue_cnt;
    axi_pkg::len_t          r_deliv_cnt;
    logic                   r_rvalid;

    logic w_ar_hs;
    logic w_r_hs;
    logic w_more;
    logic w_issue;

    // ====================
    // Handshakes
    // ====================

    assign w_ar_hs = i_arvalid && o_arready;
    assign w_r_hs  = r_rvalid && i_rready;
    assign w_more  = (r_state == RD_BURST) && (r_issue_cnt <= {1'b0, r_len});

    // Read ahead when the output register is free or drains this clock
    assign w_issue = w_more && (!r_rvalid || i_rready);

    always_ff @(posedge i_aclk) begin
        if (!i_areset_n) begin
            r_state <= RD_IDLE;
        end else begin
            case (r_state)
                RD_IDLE:  if (w_ar_hs) r_state <= RD_BURST;
                RD_BURST: if (w_r_hs && o_rlast) r_state <= RD_IDLE;
                default:  r_state <= RD_IDLE;
            endcase
        end
    end

    // Beat counters and output valid
    always_ff @(posedge i_aclk) begin
        if (!i_areset_n) begin
            r_issue_cnt <= '0;
            r_deliv_cnt <= '0;
            r_rvalid    <= 1'b0;
        end else begin
            if (w_ar_hs) begin
                r_issue_cnt <= '0;
                r_deliv_cnt <= '0;
            end else begin
                if (w_issue) r_issue_cnt <= r_issue_cnt + 9'd1;
                if (w_r_hs)  r_deliv_cnt <= r_deliv_cnt + 8'd1;
            end
            if (w_issue) begin
                r_rvalid <= 1'b1;
            end else if (w_r_hs) begin
                r_rvalid <= 1'b0;
            end
        end
    end

    // Burst attributes captured at AR
    always_ff @(posedge i_aclk) begin
        if (w_ar_hs) begin
            r_rid   <= i_arid;
            r_len   <= i_arlen;
            r_legal <= axi_pkg::burst_legal(i_arsize, i_arburst, i_arlen);
        end
    end

    axi_burst_addr u_addr (
        .i_aclk     (i_aclk),
        .i_areset_n (i_areset_n),
        .i_load     (w_ar_hs),
        .i_addr     (i_araddr),
        .i_len      (i_arlen),
        .i_burst    (i_arburst),
        .i_step     (w_issue),
        .o_idx      (mem.rd_idx)
    );

    assign mem.rd_en = w_issue && r_legal;

    assign o_arready = (r_state == RD_IDLE);
    assign o_rid     = r_rid;
    assign o_rresp   = r_legal ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
    assign o_rlast   = r_rvalid && (r_deliv_cnt == r_len);
    assign o_rvalid  = r_rvalid;

endmodule

// ==== rtl/axi_wr_engine.sv ====
// One write burst at a time; beat count comes from AWLEN, WLAST is not checked
`timescale 1ns/10ps
`include "sram_defs.svh"

module axi_wr_engine (
    input  logic                    i_aclk,
    input  logic                    i_areset_n,
    // AW channel
    input  logic [`SRAM_ID_W-1:0]   i_awid,
    input  logic [`SRAM_ADDR_W-1:0] i_awaddr,
    input  axi_pkg::len_t           i_awlen,
    input  axi_pkg::size_t          i_awsize,
    input  axi_pkg::burst_e         i_awburst,
    input  logic                    i_awvalid,
    output logic                    o_awready,
    // W channel
    input  sram_pkg::word_t         i_wdata,
    input  sram_pkg::strb_t         i_wstrb,
    input  logic                    i_wvalid,
    output logic                    o_wready,
    // B channel
    output logic [`SRAM_ID_W-1:0]   o_bid,
    output axi_pkg::resp_e          o_bresp,
    output logic                    o_bvalid,
    input  logic                    i_bready,
    sram_mem_if.wr_port             mem
);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    wr_state_e             r_state;
    logic [`SRAM_ID_W-1:0] r_bid;
    axi_pkg::len_t         r_len;
    logic                  r_legal;
    axi_pkg::len_t         r_beat_cnt;

    logic w_aw_hs;
    logic w_w_hs;
    logic w_b_hs;
    logic w_last_beat;

    // ====================
    // Handshakes
    // ====================

    assign w_aw_hs     = i_awvalid && o_awready;
    assign w_w_hs      = i_wvalid && o_wready;
    assign w_b_hs      = o_bvalid && i_bready;
    assign w_last_beat = (r_beat_cnt == r_len);

    // ====================
    // Controller
    // ====================

    always_ff @(posedge i_aclk) begin
        if (!i_areset_n) begin
            r_state    <= WR_IDLE;
            r_beat_cnt <= '0;
        end else begin
            case (r_state)
                WR_IDLE: begin
                    if (w_aw_hs) begin
                        r_state    <= WR_DATA;
                        r_beat_cnt <= '0;
                    end
                end
                WR_DATA: begin
                    if (w_w_hs) begin
                        if (w_last_beat) begin
                            r_state <= WR_RESP;
                        end else begin
                            r_beat_cnt <= r_beat_cnt + 8'd1;
                        end
                    end
                end
                WR_RESP: begin
                    // Response must drain before the next AW
                    if (w_b_hs) r_state <= WR_IDLE;
                end
                default: begin
                    r_state <= WR_IDLE;
                end
            endcase
        end
    end

    // ID and legality held until the response
    always_ff @(posedge i_aclk) begin
        if (w_aw_hs) begin
            r_bid   <= i_awid;
            r_len   <= i_awlen;
            r_legal <= axi_pkg::burst_legal(i_awsize, i_awburst, i_awlen);
        end
    end

    axi_burst_addr u_addr (
        .i_aclk     (i_aclk),
        .i_areset_n (i_areset_n),
        .i_load     (w_aw_hs),
        .i_addr     (i_awaddr),
        .i_len      (i_awlen),
        .i_burst    (i_awburst),
        .i_step     (w_w_hs),
        .o_idx      (mem.wr_idx)
    );

    // Beat lands in the array on its own handshake edge
    assign mem.wr_en   = w_w_hs && r_legal;
    assign mem.wr_data = i_wdata;
    assign mem.wr_strb = i_wstrb;

    assign o_awready = (r_state == WR_IDLE);
    assign o_wready  = (r_state == WR_DATA);
    assign o_bvalid  = (r_state == WR_RESP);
    assign o_bid     = r_bid;
    assign o_bresp   = r_legal ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;

endmodule

// ==== rtl/sram_array.sv ====
// No reset and no init, contents are undefined until written; same-word read gets old data
`timescale 1ns/10ps
`include "sram_defs.svh"

module sram_array (
    input logic     i_aclk,
    sram_mem_if.mem mem
);

    // ====================
    // Storage
    // ====================

    sram_pkg::word_t r_ram [`SRAM_DEPTH];
    sram_pkg::word_t r_rd_data;

    // ====================
    // Read port
    // ====================

    // Registered output, holds between reads
    always_ff @(posedge i_aclk) begin
        if (mem.rd_en) begin
            r_rd_data <= r_ram[mem.rd_idx];
        end
    end

    assign mem.rd_data = r_rd_data;

    // ====================
    // Write port
    // ====================

    // One enable per byte lane
    always_ff @(posedge i_aclk) begin
        if (mem.wr_en) begin
            for (int b = 0; b < sram_pkg::WORD_BYTES; b++) begin
                if (mem.wr_strb[b]) begin
                    r_ram[mem.wr_idx][b*8 +: 8] <= mem.wr_data[b*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== rtl/sram_axi4.sv ====
// AXI4 slave, 2 KB; no lock/cache/prot/qos/user, one read and one write outstanding, WLAST unused
`timescale 1ns/10ps
`include "sram_defs.svh"

module sram_axi4 (
    input  logic                    i_aclk,
    input  logic                    i_areset_n,
    // Read address
    input  logic [`SRAM_ID_W-1:0]   i_arid,
    input  logic [`SRAM_ADDR_W-1:0] i_araddr,
    input  logic [7:0]              i_arlen,
    input  logic [2:0]              i_arsize,
    input  logic [1:0]              i_arburst,
    input  logic                    i_arvalid,
    output logic                    o_arready,
    // Read data
    output logic [`SRAM_ID_W-1:0]   o_rid,
    output logic [`SRAM_DATA_W-1:0] o_rdata,
    output logic [1:0]              o_rresp,
    output logic                    o_rlast,
    output logic                    o_rvalid,
    input  logic                    i_rready,
    // Write address
    input  logic [`SRAM_ID_W-1:0]   i_awid,
    input  logic [`SRAM_ADDR_W-1:0] i_awaddr,
    input  logic [7:0]              i_awlen,
    input  logic [2:0]              i_awsize,
    input  logic [1:0]              i_awburst,
    input  logic                    i_awvalid,
    output logic                    o_awready,
    // Write data
    input  logic [`SRAM_DATA_W-1:0] i_wdata,
    input  logic [`SRAM_DATA_W/8-1:0] i_wstrb,
    input  logic                    i_wlast,
    input  logic                    i_wvalid,
    output logic                    o_wready,
    // Write response
    output logic [`SRAM_ID_W-1:0]   o_bid,
    output logic [1:0]              o_bresp,
    output logic                    o_bvalid,
    input  logic                    i_bready
);

    sram_mem_if mem_if ();

    axi_rd_engine u_rd (
        .i_aclk     (i_aclk),
        .i_areset_n (i_areset_n),
        .i_arid     (i_arid),
        .i_araddr   (i_araddr),
        .i_arlen    (i_arlen),
        .i_arsize   (i_arsize),
        .i_arburst  (axi_pkg::burst_e'(i_arburst)),
        .i_arvalid  (i_arvalid),
        .o_arready  (o_arready),
        .o_rid      (o_rid),
        .o_rresp    (o_rresp),
        .o_rlast    (o_rlast),
        .o_rvalid   (o_rvalid),
        .i_rready   (i_rready),
        .mem        (mem_if)
    );

    // Error beats carry zero instead of stale array output
    assign o_rdata = (o_rresp == axi_pkg::RESP_OKAY) ? mem_if.rd_data : '0;

    axi_wr_engine u_wr (
        .i_aclk     (i_aclk),
        .i_areset_n (i_areset_n),
        .i_awid     (i_awid),
        .i_awaddr   (i_awaddr),
        .i_awlen    (i_awlen),
        .i_awsize   (i_awsize),
        .i_awburst  (axi_pkg::burst_e'(i_awburst)),
        .i_awvalid  (i_awvalid),
        .o_awready  (o_awready),
        .i_wdata    (i_wdata),
        .i_wstrb    (i_wstrb),
        .i_wvalid   (i_wvalid),
        .o_wready   (o_wready),
        .o_bid      (o_bid),
        .o_bresp    (o_bresp),
        .o_bvalid   (o_bvalid),
        .i_bready   (i_bready),
        .mem        (mem_if)
    );

    sram_array u_array (
        .i_aclk (i_aclk),
        .mem    (mem_if)
    );

endmodule

// ==== rtl/sram_mem_if.sv ====
// No handshake; the array takes every request and read data lags rd_en by one clock
`timescale 1ns/10ps

interface sram_mem_if;

    // ====================
    // Read group
    // ====================
    logic            rd_en;
    sram_pkg::widx_t rd_idx;
    sram_pkg::word_t rd_data;

    // ====================
    // Write group
    // ====================
    logic            wr_en;
    sram_pkg::widx_t wr_idx;
    sram_pkg::word_t wr_data;
    sram_pkg::strb_t wr_strb;

    // Read engine side
    modport rd_port (output rd_en, output rd_idx, input rd_data);

    // Write engine side
    modport wr_port (output wr_en, output wr_idx, output wr_data, output wr_strb);

    // Array side
    modport mem (
        input  rd_en, input wr_en,
        input  rd_idx, input wr_idx,
        input  wr_data, input wr_strb,
        output rd_data
    );

endinterface

// ==== rtl/sram_pkg.sv ====
// Memory-side types; word index is the byte address with the in-word offset dropped
`include "sram_defs.svh"

package sram_pkg;

    // ====================
    // Storage types
    // ====================

    // One array word, same width as the AXI data bus
    typedef logic [`SRAM_DATA_W-1:0] word_t;

    // One enable per byte lane
    typedef logic [`SRAM_DATA_W/8-1:0] strb_t;

    // Word index into the array
    typedef logic [$clog2(`SRAM_DEPTH)-1:0] widx_t;

    // ====================
    // Derived sizes
    // ====================

    // Bytes per word
    localparam int WORD_BYTES = `SRAM_DATA_W / 8;

    // Byte address bits below the word index
    localparam int OFFS_W = $clog2(WORD_BYTES);

    // Bits in a word index
    localparam int IDX_W = $bits(widx_t);

endpackage

// ==== verif/tb_sram_axi4.sv ====
// Directed AXI4 tests; only words written earlier in the run are read back and compared
`timescale 1ns/10ps
`include "sram_defs.svh"

module tb_sram_axi4;

    localparam int TIMEOUT = 1000;

    logic                      aclk;
    logic                      areset_n;
    logic [`SRAM_ID_W-1:0]     arid, rid, awid, bid;
    logic [`SRAM_ADDR_W-1:0]   araddr, awaddr;
    logic [7:0]                arlen, awlen;
    logic [2:0]                arsize, awsize;
    logic [1:0]                arburst, awburst, rresp, bresp;
    logic                      arvalid, arready, rlast, rvalid, rready;
    logic                      awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic [`SRAM_DATA_W-1:0]   rdata, wdata;
    logic [`SRAM_DATA_W/8-1:0] wstrb;

    integer          seed;
    sram_pkg::word_t model [`SRAM_DEPTH];
    sram_pkg::word_t beat_data [256];
    sram_pkg::strb_t beat_strb [256];

    sram_axi4 dut_i (
        .i_aclk (aclk), .i_areset_n (areset_n),
        .i_arid (arid), .i_araddr (araddr), .i_arlen (arlen), .i_arsize (arsize),
        .i_arburst (arburst), .i_arvalid (arvalid), .o_arready (arready),
        .o_rid (rid), .o_rdata (rdata), .o_rresp (rresp), .o_rlast (rlast),
        .o_rvalid (rvalid), .i_rready (rready),
        .i_awid (awid), .i_awaddr (awaddr), .i_awlen (awlen), .i_awsize (awsize),
        .i_awburst (awburst), .i_awvalid (awvalid), .o_awready (awready),
        .i_wdata (wdata), .i_wstrb (wstrb), .i_wlast (wlast), .i_wvalid (wvalid),
        .o_wready (wready),
        .o_bid (bid), .o_bresp (bresp), .o_bvalid (bvalid), .i_bready (bready)
    );

    always #2 aclk = ~aclk;

    // ====================
    // Checks
    // ====================

    task automatic stop_on_error();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout: %s", what);
        stop_on_error();
    endtask

    task automatic check_word(input string name, input sram_pkg::word_t got,
                              input sram_pkg::word_t exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_resp(input string name, input axi_pkg::resp_e got,
                              input axi_pkg::resp_e exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_id(input string name, input logic [`SRAM_ID_W-1:0] got,
                            input logic [`SRAM_ID_W-1:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    // ====================
    // Reference rules
    // ====================

    // 8-byte beats only and WRAP limited to 2, 4, 8 or 16 beats
    function automatic logic expected_ok(input logic [2:0] size, input axi_pkg::burst_e burst,
                                         input int beats);
        if (size != 3'd3) return 1'b0;
        if (burst != axi_pkg::BURST_WRAP) return 1'b1;
        return (beats == 2) || (beats == 4) || (beats == 8) || (beats == 16);
    endfunction

    function automatic int next_idx(input int idx, input axi_pkg::burst_e burst,
                                    input int beats);
        int base;
        base = (idx / beats) * beats;
        case (burst)
            axi_pkg::BURST_INCR: return (idx + 1) % `SRAM_DEPTH;
            axi_pkg::BURST_WRAP: return base + ((idx + 1 - base) % beats);
            default:             return idx;
        endcase
    endfunction

    task automatic fill_beats(input int beats, input sram_pkg::strb_t strb);
        for (int b = 0; b < beats; b++) begin
            beat_data[b] = {$random(seed), $random(seed)};
            beat_strb[b] = strb;
        end
    endtask

    // ====================
    // Bus tasks
    // ====================

    task automatic axi_write_burst(input logic [`SRAM_ID_W-1:0] id,
                                   input logic [`SRAM_ADDR_W-1:0] addr, input int beats,
                                   input logic [2:0] size, input axi_pkg::burst_e burst);
        int   idx;
        int   waits;
        logic ok;
        ok  = expected_ok(size, burst, beats);
        idx = addr >> 3;
        @(posedge aclk); #1;
        awid    = id;
        awaddr  = addr;
        awlen   = 8'(beats - 1);
        awsize  = size;
        awburst = burst;
        awvalid = 1'b1;
        waits   = 0;
        @(negedge aclk);
        while (!awready) begin
            waits++;
            if (waits > TIMEOUT) timeout_fail("AW handshake never completed");
            @(negedge aclk);
        end
        @(posedge aclk); #1;
        awvalid = 1'b0;
        for (int b = 0; b < beats; b++) begin
            if (b > 0) begin
                @(posedge aclk); #1;
            end
            wdata  = beat_data[b];
            wstrb  = beat_strb[b];
            wlast  = (b == beats - 1);
            wvalid = 1'b1;
            waits  = 0;
            @(negedge aclk);
            while (!wready) begin
                waits++;
                if (waits > TIMEOUT) timeout_fail("W beat never accepted");
                @(negedge aclk);
            end
            // Beat lands at the coming edge
            if (ok) begin
                for (int k = 0; k < 8; k++) begin
                    if (beat_strb[b][k]) model[idx][k*8 +: 8] = beat_data[b][k*8 +: 8];
                end
            end
            idx = next_idx(idx, burst, beats);
        end
        @(posedge aclk); #1;
        wvalid = 1'b0;
        wlast  = 1'b0;
        waits  = 0;
        forever begin
            bready = ({$random(seed)} % 3) != 0;
            @(negedge aclk);
            if (bvalid && bready) break;
            waits++;
            if (waits > TIMEOUT) timeout_fail("B response never arrived");
            @(posedge aclk); #1;
        end
        check_resp("o_bresp", axi_pkg::resp_e'(bresp),
                   ok ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR);
        check_id("o_bid", bid, id);
        @(posedge aclk); #1;
        bready = 1'b0;
    endtask

    task automatic axi_read_burst(input logic [`SRAM_ID_W-1:0] id,
                                  input logic [`SRAM_ADDR_W-1:0] addr, input int beats,
                                  input logic [2:0] size, input axi_pkg::burst_e burst,
                                  input logic gaps);
        int   idx;
        int   waits;
        int   beat;
        logic ok;
        ok  = expected_ok(size, burst, beats);
        idx = addr >> 3;
        @(posedge aclk); #1;
        arid    = id;
        araddr  = addr;
        arlen   = 8'(beats - 1);
        arsize  = size;
        arburst = burst;
        arvalid = 1'b1;
        waits   = 0;
        @(negedge aclk);
        while (!arready) begin
            waits++;
            if (waits > TIMEOUT) timeout_fail("AR handshake never completed");
            @(negedge aclk);
        end
        @(posedge aclk); #1;
        arvalid = 1'b0;
        beat    = 0;
        waits   = 0;
        while (beat < beats) begin
            rready = gaps ? (({$random(seed)} % 4) != 0) : 1'b1;
            @(negedge aclk);
            if (rvalid && rready) begin
                check_word("o_rdata", rdata, ok ? model[idx] : '0);
                check_resp("o_rresp", axi_pkg::resp_e'(rresp),
                           ok ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR);
                check_id("o_rid", rid, id);
                check_flag("o_rlast", rlast, beat == beats - 1);
                idx   = next_idx(idx, burst, beats);
                beat++;
                waits = 0;
            end else begin
                waits++;
                if (waits > TIMEOUT) timeout_fail("R beat never delivered");
            end
            @(posedge aclk); #1;
        end
        rready = 1'b0;
    endtask

    // ====================
    // Directed tests
    // ====================

    task automatic reset_and_latency();
        check_flag("o_arready", arready, 1'b1);
        check_flag("o_awready", awready, 1'b1);
        check_flag("o_rvalid", rvalid, 1'b0);
        check_flag("o_wready", wready, 1'b0);
        check_flag("o_bvalid", bvalid, 1'b0);
        @(posedge aclk); #1;
        arid    = 4'h3;
        araddr  = '0;
        arlen   = 8'd0;
        arsize  = 3'd3;
        arburst = axi_pkg::BURST_INCR;
        arvalid = 1'b1;
        // arready is high here, so the handshake is on the next edge
        @(posedge aclk); #1;
        arvalid = 1'b0;
        @(negedge aclk);
        check_flag("o_rvalid", rvalid, 1'b0);
        @(negedge aclk);
        check_flag("o_rvalid", rvalid, 1'b1);
        @(posedge aclk); #1;
        rready = 1'b1;
        @(negedge aclk);
        check_flag("o_rlast", rlast, 1'b1);
        check_id("o_rid", rid, 4'h3);
        @(posedge aclk); #1;
        rready = 1'b0;
    endtask

    initial begin
        seed = 32'he938;
        aclk = 1'b0;
        areset_n = 1'b0;
        {arid, araddr, arlen, arsize, arburst, arvalid, rready} = '0;
        {awid, awaddr, awlen, awsize, awburst, awvalid} = '0;
        {wdata, wstrb, wlast, wvalid, bready} = '0;
        repeat (16) @(posedge aclk);
        #1 areset_n = 1'b1;
        @(negedge aclk);

        reset_and_latency();

        // INCR 16 beats over words 32..47
        fill_beats(16, 8'hFF);
        axi_write_burst(4'h1, 11'h100, 16, 3'd3, axi_pkg::BURST_INCR);
        axi_read_burst(4'h2, 11'h100, 16, 3'd3, axi_pkg::BURST_INCR, 1'b1);

        // Partial strobes on word 40
        fill_beats(1, 8'h0F);
        axi_write_burst(4'h5, 11'h140, 1, 3'd3, axi_pkg::BURST_INCR);
        fill_beats(1, 8'hA4);
        axi_write_burst(4'h5, 11'h140, 1, 3'd3, axi_pkg::BURST_INCR);
        axi_read_burst(4'h7, 11'h140, 1, 3'd3, axi_pkg::BURST_INCR, 1'b0);

        // WRAP 4 from word 34 returns words 34, 35, 32 and 33
        axi_read_burst(4'hA, 11'h110, 4, 3'd3, axi_pkg::BURST_WRAP, 1'b1);

        // FIXED on word 60
        fill_beats(3, 8'hFF);
        axi_write_burst(4'hC, 11'h1E0, 3, 3'd3, axi_pkg::BURST_FIXED);
        axi_read_burst(4'hD, 11'h1E0, 3, 3'd3, axi_pkg::BURST_FIXED, 1'b1);

        // Size 2 is answered with SLVERR and leaves the array alone
        fill_beats(2, 8'hFF);
        axi_write_burst(4'h9, 11'h100, 2, 3'd2, axi_pkg::BURST_INCR);
        axi_read_burst(4'h6, 11'h100, 4, 3'd2, axi_pkg::BURST_INCR, 1'b1);
        axi_read_burst(4'h4, 11'h100, 4, 3'd3, axi_pkg::BURST_INCR, 1'b0);

        $display("Simulation PASSED");
        $finish;
    end

endmodule
